// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_mips
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: compile.f
mips_pkg.sv
reg_file.sv
hazard_unit.sv
decode_stage.sv
execute_stage.sv
mips_core.sv
tb_clock.sv
tb_mips.sv

// File: decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  mips_pkg::word_t     instr,
    input  mips_pkg::word_t     pc_plus4,
    input  mips_pkg::fwd_sel_e  d_fwd_a,
    input  mips_pkg::fwd_sel_e  d_fwd_b,
    input  mips_pkg::word_t     m_alu,
    input  mips_pkg::word_t     w_data,
    input  logic                w_we,
    input  mips_pkg::reg_addr_t w_addr,
    output mips_pkg::ctrl_t     ctrl,
    output mips_pkg::reg_addr_t rs,
    output mips_pkg::reg_addr_t rt,
    output logic                is_branch,
    output mips_pkg::word_t     op_a,
    output mips_pkg::word_t     op_b,
    output mips_pkg::word_t     imm,
    output mips_pkg::word_t     next_pc
);

    mips_pkg::word_t rd1;
    mips_pkg::word_t rd2;
    mips_pkg::word_t target;

    reg_file rf0 (
        .clk  (clk),
        .rst_n(rst_n),
        .ra1  (instr[25:21]),
        .ra2  (instr[20:16]),
        .we   (w_we),
        .wa   (w_addr),
        .wd   (w_data),
        .rd1  (rd1),
        .rd2  (rd2)
    );

    ////////// Control decode //////////
    // rs and rt report only the registers actually read
    always_comb begin
        ctrl      = '0;
        rs        = '0;
        rt        = '0;
        is_branch = 1'b0;
        case (instr[31:26])
            mips_pkg::OP_SPECIAL: begin
                case (instr[5:0])
                    mips_pkg::FN_ADDU: ctrl.alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUBU: ctrl.alu_op = mips_pkg::ALU_SUB;
                    default:           ctrl.alu_op = mips_pkg::ALU_ADD;
                endcase
                if (instr[5:0] == mips_pkg::FN_ADDU || instr[5:0] == mips_pkg::FN_SUBU) begin
                    ctrl.reg_write = 1'b1;
                    ctrl.dest      = instr[15:11];                 // rd
                    rs             = instr[25:21];
                    rt             = instr[20:16];
                end
            end
            mips_pkg::OP_ORI: begin
                ctrl = '{1'b1, 1'b0, 1'b0, mips_pkg::ALU_OR, 1'b1, instr[20:16]};
                rs   = instr[25:21];
            end
            mips_pkg::OP_LUI: begin
                ctrl = '{1'b1, 1'b0, 1'b0, mips_pkg::ALU_LUI, 1'b1, instr[20:16]};
            end
            mips_pkg::OP_LW: begin
                ctrl = '{1'b1, 1'b1, 1'b0, mips_pkg::ALU_ADD, 1'b1, instr[20:16]};
                rs   = instr[25:21];
            end
            mips_pkg::OP_SW: begin
                ctrl = '{1'b0, 1'b0, 1'b1, mips_pkg::ALU_ADD, 1'b1, 5'd0};
                rs   = instr[25:21];
                rt   = instr[20:16];
            end
            mips_pkg::OP_BEQ: begin
                is_branch = 1'b1;
                rs        = instr[25:21];
                rt        = instr[20:16];
            end
            default: ctrl = '0;                                    // Unknown is a bubble
        endcase
        if (ctrl.dest == 5'd0) begin
            ctrl.reg_write = 1'b0;                                 // r0 is never written
        end
    end

    assign op_a = mips_pkg::fwd_mux(d_fwd_a, rd1, m_alu, w_data);
    assign op_b = mips_pkg::fwd_mux(d_fwd_b, rd2, m_alu, w_data);
    assign imm  = {16'h0000, instr[15:0]};

    ////////// Next PC //////////
    // pc_plus4 follows the delay slot, so the slot PC is pc_plus4 - 4
    assign target  = pc_plus4 - 32'd4 + {{14{instr[15]}}, instr[15:0], 2'b00};
    assign next_pc = (is_branch && op_a == op_b) ? target : pc_plus4;

endmodule

// File: execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  mips_pkg::id_ex_t   ex,
    input  mips_pkg::fwd_sel_e e_fwd_a,
    input  mips_pkg::fwd_sel_e e_fwd_b,
    input  mips_pkg::word_t    m_alu,
    input  mips_pkg::word_t    w_data,
    output mips_pkg::word_t    alu_result,
    output mips_pkg::word_t    store_data
);

    mips_pkg::word_t src_a;
    mips_pkg::word_t src_b;
    mips_pkg::word_t rt_val;

    ////////// Operands //////////
    assign src_a  = mips_pkg::fwd_mux(e_fwd_a, ex.op_a, m_alu, w_data);
    assign rt_val = mips_pkg::fwd_mux(e_fwd_b, ex.op_b, m_alu, w_data);
    assign src_b  = ex.ctrl.alu_b_imm ? ex.imm : rt_val;   // Zero-extended immediate

    assign store_data = rt_val;

    ////////// ALU //////////
    always_comb begin
        case (ex.ctrl.alu_op)
            mips_pkg::ALU_ADD: alu_result = src_a + src_b;
            mips_pkg::ALU_SUB: alu_result = src_a - src_b;
            mips_pkg::ALU_OR:  alu_result = src_a | src_b;
            mips_pkg::ALU_LUI: alu_result = {src_b[15:0], 16'h0000};
            default:           alu_result = '0;
        endcase
    end

endmodule

// File: hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
    input  mips_pkg::reg_addr_t d_rs,
    input  mips_pkg::reg_addr_t d_rt,
    input  logic                d_is_branch,
    input  mips_pkg::ctrl_t     e_ctrl,
    input  mips_pkg::ctrl_t     m_ctrl,
    input  mips_pkg::ctrl_t     w_ctrl,
    input  mips_pkg::reg_addr_t e_rs,
    input  mips_pkg::reg_addr_t e_rt,
    input  mips_pkg::reg_addr_t m_rt,
    output logic                stall,
    output mips_pkg::fwd_sel_e  d_fwd_a,
    output mips_pkg::fwd_sel_e  d_fwd_b,
    output mips_pkg::fwd_sel_e  e_fwd_a,
    output mips_pkg::fwd_sel_e  e_fwd_b,
    output logic                m_fwd_store
);

    // Stage c will write register r, never r0
    function automatic logic hit(mips_pkg::ctrl_t c, mips_pkg::reg_addr_t r);
        return c.reg_write && r != 5'd0 && c.dest == r;
    endfunction

    // Newest non-load producer wins
    function automatic mips_pkg::fwd_sel_e pick(mips_pkg::ctrl_t m, mips_pkg::ctrl_t w,
                                                mips_pkg::reg_addr_t r);
        if (hit(m, r) && !m.mem_read) begin
            return mips_pkg::FWD_M;
        end else if (hit(w, r)) begin
            return mips_pkg::FWD_W;
        end
        return mips_pkg::FWD_NONE;
    endfunction

    logic e_dep;
    logic m_dep;

    assign e_dep = hit(e_ctrl, d_rs) || hit(e_ctrl, d_rt);
    assign m_dep = hit(m_ctrl, d_rs) || hit(m_ctrl, d_rt);

    ////////// Stall //////////
    assign stall = (e_dep && (e_ctrl.mem_read || d_is_branch)) ||
                   (m_dep && m_ctrl.mem_read && d_is_branch);    // beq waits on load in M

    ////////// Forward selects //////////
    assign d_fwd_a = pick(m_ctrl, w_ctrl, d_rs);
    assign d_fwd_b = pick(m_ctrl, w_ctrl, d_rt);
    assign e_fwd_a = pick(m_ctrl, w_ctrl, e_rs);
    assign e_fwd_b = pick(m_ctrl, w_ctrl, e_rt);

    assign m_fwd_store = m_ctrl.mem_write && hit(w_ctrl, m_rt);  // Store data from W

endmodule

// File: mips_core.sv
`timescale 1ns/1ps

module mips_core #(
    parameter mips_pkg::word_t RESET_PC = 32'h3000
) (
    input  logic                clk,
    input  logic                rst_n,
    input  mips_pkg::word_t     i_inst_rdata,
    input  mips_pkg::word_t     m_data_rdata,
    output mips_pkg::word_t     i_inst_addr,
    output mips_pkg::word_t     m_data_addr,
    output mips_pkg::word_t     m_data_wdata,
    output logic [3:0]          m_data_byteen,
    output mips_pkg::word_t     m_inst_addr,
    output logic                w_grf_we,
    output mips_pkg::reg_addr_t w_grf_addr,
    output mips_pkg::word_t     w_grf_wdata,
    output mips_pkg::word_t     w_inst_addr
);

    mips_pkg::word_t     pc;
    mips_pkg::word_t     fd_pc;
    mips_pkg::word_t     fd_instr;
    mips_pkg::id_ex_t    id_ex;
    mips_pkg::ex_mem_t   ex_mem;
    mips_pkg::mem_wb_t   mem_wb;

    mips_pkg::ctrl_t     d_ctrl;
    mips_pkg::reg_addr_t d_rs;
    mips_pkg::reg_addr_t d_rt;
    logic                d_is_branch;
    mips_pkg::word_t     d_op_a;
    mips_pkg::word_t     d_op_b;
    mips_pkg::word_t     d_imm;
    mips_pkg::word_t     next_pc;
    mips_pkg::word_t     e_alu;
    mips_pkg::word_t     e_store;

    logic                stall;
    logic                m_fwd_store;
    mips_pkg::fwd_sel_e  d_fwd_a;
    mips_pkg::fwd_sel_e  d_fwd_b;
    mips_pkg::fwd_sel_e  e_fwd_a;
    mips_pkg::fwd_sel_e  e_fwd_b;

    ////////// Fetch //////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc       <= RESET_PC;
            fd_pc    <= '0;
            fd_instr <= '0;                                 // Decodes as a bubble
        end else if (!stall) begin
            pc       <= next_pc;
            fd_pc    <= pc;
            fd_instr <= i_inst_rdata;
        end
    end

    assign i_inst_addr = pc;

    ////////// Decode //////////
    decode_stage dec0 (
        .clk(clk), .rst_n(rst_n),
        .instr(fd_instr), .pc_plus4(pc + 32'd4),
        .d_fwd_a(d_fwd_a), .d_fwd_b(d_fwd_b),
        .m_alu(ex_mem.alu_result), .w_data(mem_wb.wdata),
        .w_we(w_grf_we), .w_addr(w_grf_addr),
        .ctrl(d_ctrl), .rs(d_rs), .rt(d_rt), .is_branch(d_is_branch),
        .op_a(d_op_a), .op_b(d_op_b), .imm(d_imm), .next_pc(next_pc)
    );

    hazard_unit haz0 (
        .d_rs(d_rs), .d_rt(d_rt), .d_is_branch(d_is_branch),
        .e_ctrl(id_ex.ctrl), .m_ctrl(ex_mem.ctrl), .w_ctrl(mem_wb.ctrl),
        .e_rs(id_ex.rs), .e_rt(id_ex.rt), .m_rt(ex_mem.rt),
        .stall(stall),
        .d_fwd_a(d_fwd_a), .d_fwd_b(d_fwd_b),
        .e_fwd_a(e_fwd_a), .e_fwd_b(e_fwd_b),
        .m_fwd_store(m_fwd_store)
    );

    ////////// Execute //////////
    execute_stage exe0 (
        .ex(id_ex), .e_fwd_a(e_fwd_a), .e_fwd_b(e_fwd_b),
        .m_alu(ex_mem.alu_result), .w_data(mem_wb.wdata),
        .alu_result(e_alu), .store_data(e_store)
    );

    ////////// Pipeline registers //////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex  <= '0;
            ex_mem <= '0;
            mem_wb <= '0;
        end else begin
            if (stall) begin
                id_ex <= '0;
            end else begin
                id_ex <= '{fd_pc, d_ctrl, d_rs, d_rt, d_op_a, d_op_b, d_imm};
            end
            ex_mem <= '{id_ex.pc, id_ex.ctrl, e_alu, e_store, id_ex.rt};
            mem_wb <= '{ex_mem.pc, ex_mem.ctrl,
                        ex_mem.ctrl.mem_read ? m_data_rdata : ex_mem.alu_result};
        end
    end

    ////////// Memory //////////
    assign m_data_addr   = ex_mem.alu_result;
    assign m_data_wdata  = m_fwd_store ? mem_wb.wdata : ex_mem.store_data;
    assign m_data_byteen = ex_mem.ctrl.mem_write ? 4'hf : 4'h0;   // Word stores only
    assign m_inst_addr   = ex_mem.pc;

    ////////// Write-back //////////
    assign w_grf_we    = mem_wb.ctrl.reg_write;
    assign w_grf_addr  = mem_wb.ctrl.dest;
    assign w_grf_wdata = mem_wb.wdata;
    assign w_inst_addr = mem_wb.pc;

endmodule

// File: mips_pkg.sv
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_BEQ     = 6'h04,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23
    } funct_e;

    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_OR,
        ALU_LUI                         // Immediate into upper half
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_NONE,                       // Register file or latched value
        FWD_M,                          // ALU result held in M
        FWD_W                           // Write-back data
    } fwd_sel_e;

    typedef struct packed {
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        alu_op_e   alu_op;
        logic      alu_b_imm;
        reg_addr_t dest;
    } ctrl_t;

    typedef struct packed {
        word_t     pc;
        ctrl_t     ctrl;
        reg_addr_t rs;
        reg_addr_t rt;
        word_t     op_a;
        word_t     op_b;
        word_t     imm;
    } id_ex_t;

    typedef struct packed {
        word_t     pc;
        ctrl_t     ctrl;
        word_t     alu_result;
        word_t     store_data;
        reg_addr_t rt;
    } ex_mem_t;

    typedef struct packed {
        word_t pc;
        ctrl_t ctrl;
        word_t wdata;                   // Load data already selected
    } mem_wb_t;

    // Operand source select shared by the D and E stages
    function automatic word_t fwd_mux(fwd_sel_e sel, word_t held, word_t m_val, word_t w_val);
        case (sel)
            FWD_M:   return m_val;
            FWD_W:   return w_val;
            default: return held;
        endcase
    endfunction

endpackage

// File: reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                clk,
    input  logic                rst_n,
    input  mips_pkg::reg_addr_t ra1,
    input  mips_pkg::reg_addr_t ra2,
    input  logic                we,
    input  mips_pkg::reg_addr_t wa,
    input  mips_pkg::word_t     wd,
    output mips_pkg::word_t     rd1,
    output mips_pkg::word_t     rd2
);

    mips_pkg::word_t regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regs <= '{default: '0};
        end else if (we && wa != 5'd0) begin
            regs[wa] <= wd;
        end
    end

    // Same-cycle write passes through to the reader
    assign rd1 = (ra1 == 5'd0)            ? '0 :
                 (we && wa == ra1)        ? wd :
                                            regs[ra1];

    assign rd2 = (ra2 == 5'd0)            ? '0 :
                 (we && wa == ra2)        ? wd :
                                            regs[ra2];

endmodule

// File: tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int HALF_PERIOD  = 4,                 // 8 ns clock
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;                              // Released on a rising edge
    end

endmodule

// File: tb_mips.sv
`timescale 1ns/1ps

module tb_mips;

    localparam logic [31:0] RESET_PC        = 32'h3000;
    localparam logic [31:0] SEED            = 32'h3eb38b24;
    localparam int          PROG_LEN        = 200;
    localparam int          LOOP_IDX        = PROG_LEN - 2;
    localparam int          LAST_BR_IDX     = LOOP_IDX - 5;     // Target stays inside program
    localparam logic [31:0] LOOP_PC         = RESET_PC + 32'(LOOP_IDX * 4);
    localparam int          WATCHDOG_CYCLES = PROG_LEN * 3 + 50;

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] value;
    } wb_rec_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] addr;
        logic [31:0] data;
    } st_rec_t;

    logic        clk;
    logic        rst_n;
    logic [31:0] i_inst_rdata;
    logic [31:0] m_data_rdata;
    logic [31:0] i_inst_addr;
    logic [31:0] m_data_addr;
    logic [31:0] m_data_wdata;
    logic [3:0]  m_data_byteen;
    logic [31:0] m_inst_addr;
    logic        w_grf_we;
    logic [4:0]  w_grf_addr;
    logic [31:0] w_grf_wdata;
    logic [31:0] w_inst_addr;

    logic [31:0] prog [256];
    logic [31:0] dmem [64];
    logic [31:0] rng;
    wb_rec_t     wb_q [$];
    st_rec_t     st_q [$];
    wb_rec_t     exp_wb;
    st_rec_t     exp_st;
    int          cycles;

    tb_clock clk0 (.clk(clk), .rst_n(rst_n));

    mips_core #(.RESET_PC(RESET_PC)) dut0 (
        .clk(clk), .rst_n(rst_n),
        .i_inst_rdata(i_inst_rdata), .m_data_rdata(m_data_rdata),
        .i_inst_addr(i_inst_addr), .m_data_addr(m_data_addr),
        .m_data_wdata(m_data_wdata), .m_data_byteen(m_data_byteen),
        .m_inst_addr(m_inst_addr), .w_grf_we(w_grf_we), .w_grf_addr(w_grf_addr),
        .w_grf_wdata(w_grf_wdata), .w_inst_addr(w_inst_addr)
    );

    //////////////////////////////
    // Memories
    assign i_inst_rdata = (i_inst_addr[31:10] == 22'd12) ? prog[i_inst_addr[9:2]] : 32'h0;
    assign m_data_rdata = dmem[m_data_addr[7:2]];

    always @(posedge clk) begin
        if (m_data_byteen != 4'h0) begin
            dmem[m_data_addr[7:2]] <= m_data_wdata;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] fill_word(input int a);
        return {16'hda7a, 8'h00, a[5:0], 2'b00};           // Byte address in low bits
    endfunction

    task automatic build_program();
        logic [31:0] r;
        logic [4:0]  ra;
        logic [4:0]  rb;
        logic [4:0]  rc;
        logic [4:0]  rt_br;
        logic [15:0] off;
        logic [15:0] br_off;
        logic        in_slot;
        in_slot = 1'b0;
        for (int i = 0; i < 256; i++) begin
            prog[i] = 32'h0;
        end
        for (int i = 0; i < LOOP_IDX; i++) begin
            rng    = xorshift(rng);
            r      = rng;
            ra     = {2'b00, r[2:0]};                       // r0 to r7
            rb     = {2'b00, r[5:3]};
            rc     = {2'b00, r[8:6]};
            off    = {8'h00, r[17:12], 2'b00};
            rt_br  = r[18] ? ra : rb;                       // Equal half the time
            br_off = 16'd2 + {14'd0, (r[20:19] == 2'd3) ? 2'd2 : r[20:19]};
            case (r[11:9])
                3'd0:       prog[i] = {6'h00, ra, rb, rc, 5'd0, 6'h21};  // addu
                3'd1:       prog[i] = {6'h00, ra, rb, rc, 5'd0, 6'h23};  // subu
                3'd2:       prog[i] = {6'h0d, ra, rb, r[31:16]};          // ori
                3'd3:       prog[i] = {6'h0f, 5'd0, rb, r[31:16]};        // lui
                3'd5:       prog[i] = {6'h2b, 5'd0, rb, off};             // sw
                3'd6: begin
                    if (!in_slot && i <= LAST_BR_IDX) begin
                        prog[i] = {6'h04, ra, rt_br, br_off};
                    end else begin
                        prog[i] = {6'h00, ra, rb, rc, 5'd0, 6'h21};
                    end
                end
                default:    prog[i] = {6'h23, 5'd0, rb, off};             // lw
            endcase
            in_slot = (prog[i][31:26] == 6'h04);
        end
        prog[LOOP_IDX] = {6'h04, 5'd0, 5'd0, 16'hffff};    // Self-loop with a nop slot after it
    endtask

    //////////////////////////////
    // Sequential ISA model
    task automatic run_model();
        logic [31:0] regs [32];
        logic [31:0] mem [64];
        logic [31:0] ins;
        logic [31:0] val;
        logic [31:0] addr;
        logic [4:0]  dst;
        logic        wr;
        logic        pending;
        int          idx;
        int          nxt;
        int          tgt;
        wb_rec_t     wb;
        st_rec_t     st;
        for (int i = 0; i < 32; i++) begin
            regs[i] = 32'h0;
        end
        for (int i = 0; i < 64; i++) begin
            mem[i] = fill_word(i);
        end
        idx     = 0;
        tgt     = 0;
        pending = 1'b0;
        while (idx != LOOP_IDX) begin
            ins     = prog[idx];
            nxt     = pending ? tgt : idx + 1;              // Delay slot already ran
            pending = 1'b0;
            wr      = 1'b0;
            dst     = ins[20:16];
            val     = 32'h0;
            addr    = regs[ins[25:21]] + {16'h0000, ins[15:0]};
            case (ins[31:26])
                6'h00: begin
                    dst = ins[15:11];
                    wr  = (ins[5:0] == 6'h21) || (ins[5:0] == 6'h23);
                    val = (ins[5:0] == 6'h21) ? regs[ins[25:21]] + regs[ins[20:16]]
                                              : regs[ins[25:21]] - regs[ins[20:16]];
                end
                6'h0d: begin
                    wr  = 1'b1;
                    val = regs[ins[25:21]] | {16'h0000, ins[15:0]};
                end
                6'h0f: begin
                    wr  = 1'b1;
                    val = {ins[15:0], 16'h0000};
                end
                6'h23: begin
                    wr  = 1'b1;
                    val = mem[addr[7:2]];
                end
                6'h2b: begin
                    mem[addr[7:2]] = regs[ins[20:16]];
                    st.pc          = RESET_PC + 32'(idx) * 32'd4;
                    st.addr        = addr;
                    st.data        = regs[ins[20:16]];
                    st_q.push_back(st);
                end
                6'h04: begin
                    if (regs[ins[25:21]] == regs[ins[20:16]]) begin
                        pending = 1'b1;
                        tgt     = idx + 1 + 32'($signed(ins[15:0]));
                    end
                end
                default: wr = 1'b0;
            endcase
            if (wr && dst != 5'd0) begin                    // r0 stays zero
                regs[dst] = val;
                wb.pc     = RESET_PC + 32'(idx) * 32'd4;
                wb.rd     = dst;
                wb.value  = val;
                wb_q.push_back(wb);
            end
            idx = nxt;
        end
    endtask

    task automatic report_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        $display("[ERROR] t=%0t %s expected %h actual %h", $time, name, expected, actual);
        $display("sim failed");
        $fatal(1, "Output mismatch");
    endtask

    task automatic report_failure(input string what);
        $display("t=%0t %s", $time, what);
        $display("sim failed");
        $fatal(1, "Unexpected event");
    endtask

    //////////////////////////////
    // Checks on the falling edge
    always @(negedge clk) begin
        if (!rst_n) begin
            cycles = 0;
            assert (i_inst_addr == RESET_PC)
                else report_value("i_inst_addr", RESET_PC, i_inst_addr);
            assert (!w_grf_we) else report_value("w_grf_we", 32'd0, {31'd0, w_grf_we});
            assert (m_data_byteen == 4'h0)
                else report_value("m_data_byteen", 32'd0, {28'd0, m_data_byteen});
        end else begin
            if (cycles == 0) begin
                assert (i_inst_addr == RESET_PC)
                    else report_value("i_inst_addr", RESET_PC, i_inst_addr);
            end
            cycles = cycles + 1;
            if (w_grf_we && wb_q.size() == 0) begin
                report_failure("A register write-back came after all expected ones");
            end else if (w_grf_we) begin
                exp_wb = wb_q.pop_front();
                assert (w_inst_addr == exp_wb.pc)
                    else report_value("w_inst_addr", exp_wb.pc, w_inst_addr);
                assert (w_grf_addr == exp_wb.rd)
                    else report_value("w_grf_addr", {27'd0, exp_wb.rd}, {27'd0, w_grf_addr});
                assert (w_grf_wdata == exp_wb.value)
                    else report_value("w_grf_wdata", exp_wb.value, w_grf_wdata);
            end
            if (m_data_byteen != 4'h0 && st_q.size() == 0) begin
                report_failure("A store came after all expected ones");
            end else if (m_data_byteen != 4'h0) begin
                exp_st = st_q.pop_front();
                assert (m_data_byteen == 4'hf)
                    else report_value("m_data_byteen", 32'hf, {28'd0, m_data_byteen});
                assert (m_inst_addr == exp_st.pc)
                    else report_value("m_inst_addr", exp_st.pc, m_inst_addr);
                assert (m_data_addr == exp_st.addr)
                    else report_value("m_data_addr", exp_st.addr, m_data_addr);
                assert (m_data_wdata == exp_st.data)
                    else report_value("m_data_wdata", exp_st.data, m_data_wdata);
            end
        end
    end

    initial begin
        rng    = SEED;
        cycles = 0;
        for (int a = 0; a < 64; a++) begin
            dmem[a] = fill_word(a);
        end
        build_program();
        run_model();
        while (wb_q.size() != 0 || st_q.size() != 0 || i_inst_addr != LOOP_PC) begin
            @(negedge clk);
        end
        repeat (8) @(negedge clk);                          // Catch any extra write-back
        $display("sim passed");
        $finish;
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the program did not reach its final loop in %0d cycles",
                 WATCHDOG_CYCLES);
        $display("sim failed");
        $fatal(1, "Watchdog expired");
    end

endmodule
